// ==== run_sim.sh ====
#!/bin/sh
# build the beam trigger testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    -f sources.f \
    --top-module tb_beam_trigger \
    -Mdir obj_dir

./obj_dir/Vtb_beam_trigger > sim.log 2>&1
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail"
    exit 1
fi

// ==== source/beam_pkg.sv ====
// shared widths and types for the dual-beam power trigger
package beam_pkg;

    // raw input geometry
    localparam int NBITS = 5;   // signed sample width out of the delay stage
    localparam int NSAMP = 8;   // samples carried in one clock
    localparam int NCHAN = 8;   // channels that make up one beam

    // one raw beam word holds every channel and every sample of that clock
    // channel c sample s starts at bit (c*NSAMP + s)*NBITS and sample 0 is the oldest
    localparam int BEAM_W = NCHAN * NSAMP * NBITS;

    // eight 5-bit signed values sum into -128..120 so 8 signed bits are enough
    localparam int SUM_W = 8;

    // the largest square is 128*128 = 16384 which needs 15 unsigned bits
    localparam int SQ_W = 15;

    // four squares give 17 bits and the 8-sample boxcar gives 18 bits
    localparam int ENV_W = 18;
    localparam int THR_W = 18;  // thresholds compare directly against the envelope
    localparam int NTHR  = 2;   // two independently loaded thresholds

    // squares of all samples in one clock with sample 0 in the low slice
    typedef logic [NSAMP-1:0][SQ_W-1:0] sq_vec_t;

    typedef logic [ENV_W-1:0] env_t;    // decimated power envelope of one beam
    typedef logic [THR_W-1:0] thr_t;    // one threshold value

    // control states of the trigger gate
    typedef enum logic {
        CTRL_FLUSH = 1'b0,  // datapath still holds words from before reset
        CTRL_RUN   = 1'b1   // pipeline is filled and loaded thresholds may fire
    } ctrl_state_t;

endpackage

// ==== source/beam_sum_square.sv ====
`timescale 1ns/1ps

// channel sum and square of every sample for both beams
// the sums are registered first and the squares one clock later
module beam_sum_square
    import beam_pkg::*;
(
    input  logic              clk_i,
    input  logic [BEAM_W-1:0] beam_a_i,  // raw delayed beam A
    input  logic [BEAM_W-1:0] beam_b_i,  // raw delayed beam B
    output sq_vec_t           sq_a_o,    // squared beam A samples
    output sq_vec_t           sq_b_o     // squared beam B samples
);

    // summed beam of each sample kept for one stage
    logic signed [SUM_W-1:0] sum_a_q [NSAMP];
    logic signed [SUM_W-1:0] sum_b_q [NSAMP];

    // adds all eight channels of one sample slot
    // every channel value is sign extended to the sum width before the add
    function automatic logic signed [SUM_W-1:0] chan_sum(
        input logic [BEAM_W-1:0] beam,
        input int                s
    );
        logic signed [SUM_W-1:0] acc;
        logic signed [NBITS-1:0] smp;
        acc = '0;
        for (int c = 0; c < NCHAN; c++) begin
            smp = beam[(c*NSAMP + s)*NBITS +: NBITS];  // channel c of sample s
            acc = acc + SUM_W'(smp);                   // signed cast keeps the sign
        end
        return acc;
    endfunction

    // square of a summed sample
    // the result is never negative and tops out at 2^14 so the low 15 bits hold it
    function automatic logic [SQ_W-1:0] square(
        input logic signed [SUM_W-1:0] x
    );
        logic signed [2*SUM_W-1:0] prod;
        prod = x * x;   // both operands widen to 16 signed bits
        return prod[SQ_W-1:0];
    endfunction

    // stage one holds the beam sums of the word presented this clock
    always_ff @(posedge clk_i) begin
        for (int s = 0; s < NSAMP; s++) begin
            sum_a_q[s] <= chan_sum(beam_a_i, s);
            sum_b_q[s] <= chan_sum(beam_b_i, s);
        end
    end

    // stage two squares the sums registered on the previous edge
    // one multiplier per sample per beam gives the two banks
    always_ff @(posedge clk_i) begin
        for (int s = 0; s < NSAMP; s++) begin
            sq_a_o[s] <= square(sum_a_q[s]);
            sq_b_o[s] <= square(sum_b_q[s]);
        end
    end

endmodule

// ==== source/beam_trigger_top.sv ====
`timescale 1ns/1ps

// dual-beam power trigger for one beam pair
// input word to trigger_o takes four clocks through sum, square, envelope and compare
module beam_trigger_top
    import beam_pkg::*;
#(
    parameter int FLUSH_CYCLES = 6  // clocks the triggers stay off after reset
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [BEAM_W-1:0]     beam_a_i,         // raw delayed beam A
    input  logic [BEAM_W-1:0]     beam_b_i,         // raw delayed beam B
    input  logic [NTHR*THR_W-1:0] thresh_i,         // shadow load value for both thresholds
    input  logic [NTHR-1:0]       thresh_wr_i,      // shadow write strobes
    input  logic [NTHR-1:0]       thresh_update_i,  // shadow to active strobes
    output logic [3:0]            trigger_o         // raw trigger bits
);

    sq_vec_t sq_a, sq_b;     // squared samples
    env_t    env_a, env_b;   // boxcar envelopes
    logic    flush_done;     // flush timer has run out

    thresh_if thr_bus ();    // active thresholds and arm levels

    beam_sum_square u_sum_square (
        .clk_i    (clk_i),
        .beam_a_i (beam_a_i),
        .beam_b_i (beam_b_i),
        .sq_a_o   (sq_a),
        .sq_b_o   (sq_b)
    );

    envelope_max u_envelope (
        .clk_i   (clk_i),
        .sq_a_i  (sq_a),
        .sq_b_i  (sq_b),
        .env_a_o (env_a),
        .env_b_o (env_b)
    );

    flush_timer #(
        .FLUSH_CYCLES (FLUSH_CYCLES)
    ) u_flush_timer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .done_o  (flush_done)
    );

    thresh_ctrl u_thresh_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .thresh_i        (thresh_i),
        .thresh_wr_i     (thresh_wr_i),
        .thresh_update_i (thresh_update_i),
        .flush_done_i    (flush_done),
        .thr             (thr_bus.ctrl)
    );

    thresh_compare u_thresh_compare (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .env_a_i   (env_a),
        .env_b_i   (env_b),
        .thr       (thr_bus.cmp),
        .trigger_o (trigger_o)
    );

endmodule

// ==== source/envelope_max.sv ====
`timescale 1ns/1ps

// decimated boxcar power envelope of both beams
// an 8-sample boxcar decimated by 4 leaves two windows ending in each clock
// and only the larger of the two is kept
module envelope_max
    import beam_pkg::*;
(
    input  logic    clk_i,
    input  sq_vec_t sq_a_i,     // squared samples of beam A
    input  sq_vec_t sq_b_i,     // squared samples of beam B
    output env_t    env_a_o,    // envelope of beam A
    output env_t    env_b_o     // envelope of beam B
);

    // four squares fit in one bit less than the full envelope
    localparam int HALF_W = ENV_W - 1;

    logic [HALF_W-1:0] lo_a_q, hi_a_q, prev_hi_a_q;  // beam A quarter-window sums
    logic [HALF_W-1:0] lo_b_q, hi_b_q, prev_hi_b_q;  // beam B quarter-window sums

    // sum of the four squares starting at sample base
    function automatic logic [HALF_W-1:0] half_sum(
        input sq_vec_t sq,
        input int      base
    );
        logic [HALF_W-1:0] acc;
        acc = '0;
        for (int s = 0; s < NSAMP/2; s++) begin
            acc = acc + HALF_W'(sq[base + s]);
        end
        return acc;
    endfunction

    // both windows share the current low half
    // so the max only has to pick between the two high halves that border it
    function automatic env_t max_boxcar(
        input logic [HALF_W-1:0] lo,
        input logic [HALF_W-1:0] hi,
        input logic [HALF_W-1:0] prev_hi
    );
        logic [HALF_W-1:0] edge_half;
        edge_half = (prev_hi > hi) ? prev_hi : hi;  // window back into the last clock wins here
        return ENV_W'(lo) + ENV_W'(edge_half);
    endfunction

    // quarter-window sums plus the previous high half
    always_ff @(posedge clk_i) begin
        lo_a_q      <= half_sum(sq_a_i, 0);         // samples 0 to 3
        hi_a_q      <= half_sum(sq_a_i, NSAMP/2);   // samples 4 to 7
        prev_hi_a_q <= hi_a_q;                      // high half of the word before
        lo_b_q      <= half_sum(sq_b_i, 0);
        hi_b_q      <= half_sum(sq_b_i, NSAMP/2);
        prev_hi_b_q <= hi_b_q;
    end

    // envelope register one clock behind the quarter sums
    always_ff @(posedge clk_i) begin
        env_a_o <= max_boxcar(lo_a_q, hi_a_q, prev_hi_a_q);
        env_b_o <= max_boxcar(lo_b_q, hi_b_q, prev_hi_b_q);
    end

endmodule

// ==== source/flush_timer.sv ====
`timescale 1ns/1ps

// times the pipeline flush after reset
// the datapath has no reset so it holds stale words until enough clocks pass
module flush_timer #(
    parameter int FLUSH_CYCLES = 6  // clocks with triggers held off which is never below 4
) (
    input  logic clk_i,
    input  logic rst_n_i,
    output logic done_o             // high for good once the count is spent
);

    localparam int CNT_W = $clog2(FLUSH_CYCLES + 1);

    logic [CNT_W-1:0] count_q;  // clocks left in the flush

    // reloads on reset and stops at zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= CNT_W'(FLUSH_CYCLES);
        end else if (count_q != '0) begin
            count_q <= count_q - CNT_W'(1);
        end
    end

    assign done_o = (count_q == '0);  // stays high until the next reset reloads the count

endmodule

// ==== source/thresh_compare.sv ====
`timescale 1ns/1ps

// four envelope against threshold tests registered into the trigger word
module thresh_compare
    import beam_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  env_t       env_a_i,     // envelope of beam A
    input  env_t       env_b_i,     // envelope of beam B
    thresh_if.cmp      thr,
    output logic [3:0] trigger_o    // {B>thr_1, B>thr_0, A>thr_1, A>thr_0}
);

    logic [3:0] hit;    // strict tests before the arm gate

    // an envelope equal to the threshold does not fire
    assign hit[0] = (env_a_i > thr.thr_0);
    assign hit[1] = (env_a_i > thr.thr_1);
    assign hit[2] = (env_b_i > thr.thr_0);
    assign hit[3] = (env_b_i > thr.thr_1);

    // each threshold's arm level masks the two bits that test it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            trigger_o <= '0;
        end else begin
            trigger_o <= hit & {thr.arm_1, thr.arm_0, thr.arm_1, thr.arm_0};
        end
    end

endmodule

// ==== source/thresh_ctrl.sv ====
`timescale 1ns/1ps

// trigger gating and staged threshold registers
// a write fills the shadow of a threshold and an update moves it to the active copy
module thresh_ctrl
    import beam_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic [NTHR*THR_W-1:0] thresh_i,        // threshold 0 low, threshold 1 high
    input  logic [NTHR-1:0]      thresh_wr_i,      // load shadow i from thresh_i
    input  logic [NTHR-1:0]      thresh_update_i,  // copy shadow i into active i
    input  logic                 flush_done_i,     // pipeline flush is over
    thresh_if.ctrl               thr
);

    ctrl_state_t state_q, state_d;

    thr_t            shadow_q [NTHR];   // staged values waiting for an update
    thr_t            active_q [NTHR];   // values the comparator sees
    logic [NTHR-1:0] loaded_q;          // set by the first update of each threshold

    // the gate opens once after the flush and only reset closes it again
    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_FLUSH: begin
                if (flush_done_i) begin
                    state_d = CTRL_RUN;
                end
            end
            CTRL_RUN: begin
                state_d = CTRL_RUN;     // no way out short of reset
            end
            default: begin
                state_d = CTRL_FLUSH;
            end
        endcase
    end

    // control state and loaded flags
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= CTRL_FLUSH;
            loaded_q <= '0;
        end else begin
            state_q  <= state_d;
            loaded_q <= loaded_q | thresh_update_i;  // sticky until reset
        end
    end

    // threshold values
    // an update in the same clock as a write picks up the shadow from before the write
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NTHR; i++) begin
            if (thresh_wr_i[i]) begin
                shadow_q[i] <= thresh_i[i*THR_W +: THR_W];
            end
            if (thresh_update_i[i]) begin
                active_q[i] <= shadow_q[i];
            end
        end
    end

    assign thr.thr_0 = active_q[0];
    assign thr.thr_1 = active_q[1];

    // a threshold arms only in the run state and after its first update
    assign thr.arm_0 = (state_q == CTRL_RUN) && loaded_q[0];
    assign thr.arm_1 = (state_q == CTRL_RUN) && loaded_q[1];

endmodule

// ==== source/thresh_if.sv ====
`timescale 1ns/1ps

// active thresholds and arm levels going from control to the comparator
interface thresh_if
    import beam_pkg::*;
();

    thr_t thr_0;    // active threshold 0
    thr_t thr_1;    // active threshold 1
    logic arm_0;    // bits that test threshold 0 may fire
    logic arm_1;    // bits that test threshold 1 may fire

    // control side owns every signal of the bundle
    modport ctrl (output thr_0, output thr_1, output arm_0, output arm_1);

    // the comparator only reads
    modport cmp (input thr_0, input thr_1, input arm_0, input arm_1);

endinterface

// ==== sources.f ====
+incdir+test
source/beam_pkg.sv
source/thresh_if.sv
source/beam_sum_square.sv
source/envelope_max.sv
source/flush_timer.sv
source/thresh_ctrl.sv
source/thresh_compare.sv
source/beam_trigger_top.sv
test/tb_beam_trigger.sv

// ==== test/tb_beam_model.svh ====
`ifndef TB_BEAM_MODEL_SVH
`define TB_BEAM_MODEL_SVH

// reference model of the beam trigger that the testbench module includes
// all arithmetic is on plain integers with no width limits

// one raw 5-bit field read back as a two's complement integer
function automatic int sample_value(input logic [BEAM_W-1:0] beam, input int c, input int s);
    int raw;
    raw = int'(beam[(c*NSAMP + s)*NBITS +: NBITS]);
    if (raw >= (1 << (NBITS - 1))) begin
        raw = raw - (1 << NBITS);   // top bit set means a negative sample
    end
    return raw;
endfunction

// power of one sample is the square of its channel sum
function automatic int sample_power(input logic [BEAM_W-1:0] beam, input int s);
    int sum;
    sum = 0;
    for (int c = 0; c < NCHAN; c++) begin
        sum += sample_value(beam, c, s);
    end
    return sum * sum;
endfunction

// two 8-sample boxcars end inside a word once the output is decimated by 4
// one lies wholly in the word and the other reaches back into the last half of the word before
function automatic int boxcar_envelope(input logic [BEAM_W-1:0] cur,
                                       input logic [BEAM_W-1:0] prev);
    int in_word;
    int reach_back;
    in_word    = 0;
    reach_back = 0;
    for (int s = 0; s < NSAMP; s++) begin
        in_word += sample_power(cur, s);
        if (s < NSAMP/2) begin
            reach_back += sample_power(cur, s);     // oldest half of the current word
        end else begin
            reach_back += sample_power(prev, s);    // newest half of the word before
        end
    end
    return (reach_back > in_word) ? reach_back : in_word;
endfunction

// four strict comparisons, each one masked by the arm state of its threshold
function automatic logic [3:0] trigger_word(input int env_a, input int env_b, input int thr_0,
                                            input int thr_1, input logic arm_0, input logic arm_1);
    logic [3:0] word;
    word[0] = arm_0 && (env_a > thr_0);
    word[1] = arm_1 && (env_a > thr_1);
    word[2] = arm_0 && (env_b > thr_0);
    word[3] = arm_1 && (env_b > thr_1);
    return word;
endfunction

`endif

// ==== test/tb_beam_trigger.sv ====
`timescale 1ns/1ps

// self-checking testbench for beam_trigger_top
// inputs change on the falling edge and each trigger word is read back on the next falling edge
module tb_beam_trigger
    import beam_pkg::*;
();

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 5;
    localparam int          FLUSH_CYCLES = 6;
    localparam int          LATENCY      = 4;       // input word to trigger_o
    localparam int          WAIT_LIMIT   = 40;      // cycles allowed for an expected trigger
    localparam int          MAX_CYCLES   = 3000;    // bound on the whole run
    localparam logic [31:0] SEED         = 32'h6f8414f8;
    localparam thr_t        THR_LOW      = thr_t'(1000);    // any full-scale beam beats this
    localparam thr_t        THR_NEVER    = thr_t'(262143);  // above the largest possible envelope

    localparam int MODE_SMALL = 0;  // samples in -2..1
    localparam int MODE_FULL  = 1;  // coherent samples near full scale
    localparam int MODE_WIDE  = 2;  // uniform over the whole 5-bit range
    localparam int MODE_MIXED = 3;  // each beam picks one of the three above

    logic                  clk;
    logic                  rst_n;
    logic [BEAM_W-1:0]     beam_a, beam_b;
    logic [NTHR*THR_W-1:0] thresh;
    logic [NTHR-1:0]       thresh_wr, thresh_update;
    logic [3:0]            trigger;

    logic [BEAM_W-1:0] prev_a, prev_b;  // words taken one edge before the ones on the bus
    int                env_a_q[$];      // model envelopes of words still inside the DUT
    int                env_b_q[$];
    int                shadow_m[NTHR];  // model shadow thresholds
    int                active_m[NTHR];  // model active thresholds
    logic [NTHR-1:0]   loaded_m;
    int                high_edges;      // rising edges seen since reset was released
    int                errors, checks;
    int                fired, quiet;    // armed words expected with and without a trigger

    `include "tb_beam_model.svh"

    beam_trigger_top #(
        .FLUSH_CYCLES (FLUSH_CYCLES)
    ) i_beam_trigger_top (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .beam_a_i        (beam_a),
        .beam_b_i        (beam_b),
        .thresh_i        (thresh),
        .thresh_wr_i     (thresh_wr),
        .thresh_update_i (thresh_update),
        .trigger_o       (trigger)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic thr_t random_thr();
        return thr_t'($urandom % 100000);  // spans quiet small beams and loud full-scale ones
    endfunction

    function automatic logic [BEAM_W-1:0] random_beam(input int mode);
        logic [BEAM_W-1:0] word;
        logic [NSAMP-1:0]  neg;
        int                kind;
        int                v;
        word = '0;
        neg  = NSAMP'($urandom);    // full-scale samples share one sign over all channels
        kind = (mode == MODE_MIXED) ? int'($urandom % 3) : mode;
        for (int c = 0; c < NCHAN; c++) begin
            for (int s = 0; s < NSAMP; s++) begin
                case (kind)
                    MODE_SMALL: v = int'($urandom % 4) - 2;
                    MODE_FULL:  v = neg[s] ? -13 - int'($urandom % 4) : 12 + int'($urandom % 4);
                    default:    v = int'($urandom % 32) - 16;
                endcase
                word[(c*NSAMP + s)*NBITS +: NBITS] = NBITS'(v);
            end
        end
        return word;
    endfunction

    // a threshold may fire once the flush is over and it has been updated at least once
    function automatic logic armed(input int i);
        return (high_edges > FLUSH_CYCLES) && loaded_m[i];
    endfunction

    task automatic compare_word(input string name, input logic [3:0] actual,
                                input logic [3:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED time=%0d ns signal=%s actual=%b expected=%b",
                     $time, name, actual, expected);
        end
    endtask

    // applies the strobes of the edge just taken to the model registers
    task automatic update_model();
        for (int i = 0; i < NTHR; i++) begin
            if (thresh_update[i]) begin
                active_m[i] = shadow_m[i];  // still the shadow from before any write of this edge
            end
            if (thresh_wr[i]) begin
                shadow_m[i] = int'(thresh[i*THR_W +: THR_W]);
            end
        end
        if (!rst_n) begin
            loaded_m   = '0;
            high_edges = 0;
        end else begin
            loaded_m = loaded_m | thresh_update;
            if (high_edges <= FLUSH_CYCLES) begin
                high_edges++;
            end
        end
    endtask

    // checks the edge just taken, then drives the inputs for the next one
    task automatic step_cycle(input logic rst_v, input logic [NTHR-1:0] wr_v,
                              input logic [NTHR-1:0] upd_v, input thr_t thr0_v,
                              input thr_t thr1_v, input int mode);
        logic [3:0] expected;
        @(negedge clk);
        if (!rst_n) begin
            compare_word("trigger_o", trigger, 4'b0000);  // reset clears the trigger register
        end else if (env_a_q.size() == LATENCY) begin
            expected = trigger_word(env_a_q[0], env_b_q[0], active_m[0], active_m[1],
                                    armed(0), armed(1));
            compare_word("trigger_o", trigger, expected);
            if (armed(0) || armed(1)) begin
                if (expected != 4'b0000) begin
                    fired++;
                end else begin
                    quiet++;
                end
            end
        end
        if (env_a_q.size() == LATENCY) begin
            void'(env_a_q.pop_front());
            void'(env_b_q.pop_front());
        end
        update_model();
        env_a_q.push_back(boxcar_envelope(beam_a, prev_a));
        env_b_q.push_back(boxcar_envelope(beam_b, prev_b));
        prev_a        = beam_a;
        prev_b        = beam_b;
        rst_n         = rst_v;
        thresh_wr     = wr_v;
        thresh_update = upd_v;
        thresh        = {thr1_v, thr0_v};
        beam_a        = random_beam(mode);
        beam_b        = random_beam(mode);
    endtask

    task automatic hold_reset(input int n);
        for (int i = 0; i < n; i++) begin
            step_cycle(1'b0, '0, '0, random_thr(), random_thr(), MODE_WIDE);
        end
    endtask

    task automatic run_idle(input int n, input int mode);
        for (int i = 0; i < n; i++) begin
            step_cycle(1'b1, '0, '0, random_thr(), random_thr(), mode);
        end
    endtask

    // random beams with an occasional shadow write or update on either threshold
    task automatic run_random(input int n);
        logic [NTHR-1:0] wr;
        logic [NTHR-1:0] upd;
        for (int i = 0; i < n; i++) begin
            wr  = ($urandom % 8 == 0) ? NTHR'($urandom) : '0;
            upd = ($urandom % 8 == 0) ? NTHR'($urandom) : '0;
            step_cycle(1'b1, wr, upd, random_thr(), random_thr(), MODE_MIXED);
        end
    endtask

    // full-scale beams until one of the masked bits fires
    task automatic wait_for_trigger(input logic [3:0] mask);
        int n;
        for (n = 0; n < WAIT_LIMIT && (trigger & mask) == 4'b0000; n++) begin
            step_cycle(1'b1, '0, '0, random_thr(), random_thr(), MODE_FULL);
        end
        if ((trigger & mask) == 4'b0000) begin
            errors++;
            $display("ERROR: no trigger on bits %b within %0d cycles of arming", mask, WAIT_LIMIT);
        end
    endtask

    task automatic report_and_finish(input bit timed_out);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin : watchdog
        for (int n = 0; n < MAX_CYCLES; n++) begin
            @(posedge clk);
        end
        $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
        report_and_finish(1'b1);
    end

    initial begin : stimulus
        errors     = 0;
        checks     = 0;
        fired      = 0;
        quiet      = 0;
        high_edges = 0;
        loaded_m   = '0;
        prev_a     = '0;
        prev_b     = '0;
        for (int i = 0; i < NTHR; i++) begin
            shadow_m[i] = 0;
            active_m[i] = 0;
        end
        void'($urandom(SEED));
        rst_n         = 1'b0;   // the first rising edge already counts as a reset cycle
        thresh_wr     = '0;
        thresh_update = '0;
        thresh        = {random_thr(), random_thr()};
        beam_a        = random_beam(MODE_WIDE);
        beam_b        = random_beam(MODE_WIDE);
        hold_reset(RESET_CYCLES - 1);
        run_idle(20, MODE_FULL);    // loud beams but no threshold updated yet

        // only threshold 1 armed so bits 0 and 2 stay off
        step_cycle(1'b1, 2'b10, 2'b00, random_thr(), THR_LOW, MODE_FULL);
        step_cycle(1'b1, 2'b00, 2'b10, random_thr(), random_thr(), MODE_FULL);
        wait_for_trigger(4'b1010);
        run_idle(30, MODE_MIXED);

        // threshold 0 armed low, then a write alone leaves the low value active
        step_cycle(1'b1, 2'b01, 2'b00, THR_LOW, random_thr(), MODE_FULL);
        step_cycle(1'b1, 2'b00, 2'b01, random_thr(), random_thr(), MODE_FULL);
        wait_for_trigger(4'b0101);
        step_cycle(1'b1, 2'b01, 2'b00, THR_NEVER, random_thr(), MODE_FULL);
        run_idle(8, MODE_FULL);
        step_cycle(1'b1, 2'b00, 2'b01, random_thr(), random_thr(), MODE_FULL);
        run_idle(8, MODE_FULL);     // bits 0 and 2 go quiet after the update

        // write and update of threshold 1 in one cycle moves the older shadow
        step_cycle(1'b1, 2'b10, 2'b00, random_thr(), THR_NEVER, MODE_FULL);
        run_idle(8, MODE_FULL);
        step_cycle(1'b1, 2'b10, 2'b10, random_thr(), THR_LOW, MODE_FULL);
        run_idle(8, MODE_FULL);
        step_cycle(1'b1, 2'b00, 2'b10, random_thr(), random_thr(), MODE_FULL);
        wait_for_trigger(4'b1010);
        run_random(300);

        // a second reset drops the loaded flags again
        hold_reset(RESET_CYCLES);
        run_idle(20, MODE_FULL);
        step_cycle(1'b1, 2'b11, 2'b00, THR_LOW, THR_LOW, MODE_FULL);
        step_cycle(1'b1, 2'b00, 2'b11, random_thr(), random_thr(), MODE_FULL);
        wait_for_trigger(4'b1111);

        // thresholds updated right after reset still wait for the flush timer
        hold_reset(RESET_CYCLES);
        step_cycle(1'b1, 2'b00, 2'b11, random_thr(), random_thr(), MODE_FULL);
        run_idle(FLUSH_CYCLES, MODE_FULL);
        wait_for_trigger(4'b1111);
        run_random(60);

        if (fired == 0 || quiet == 0) begin
            errors++;
            $display("ERROR: armed trigger words missed one outcome (%0d fired, %0d quiet)",
                     fired, quiet);
        end
        report_and_finish(1'b0);
    end

endmodule
